//--- filelist.f
design/cart_pkg.sv
design/download_router.sv
design/rom_header_parser.sv
design/cheat_code_assembler.sv
design/ram_fill_sequencer.sv
design/cart_loader_top.sv
tests/cart_loader_tb.sv

//--- Makefile
# Verilator build for the cartridge loader testbench

VERILATOR  ?= verilator
TOP        ?= cart_loader_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/cart_loader_tb.sv
`timescale 1ns/1ps

module cart_loader_tb;

	logic                              clk_sys = 1'b0;
	logic                              RESET;
	logic                              ioctl_download;
	logic [7:0]                        ioctl_index;
	logic [cart_pkg::IOCTL_ADDR_W-1:0] ioctl_addr;
	logic [cart_pkg::IOCTL_DATA_W-1:0] ioctl_dout;
	logic                              ioctl_wr;
	cart_pkg::header_mode_e            header_mode;
	cart_pkg::region_mode_e            region_mode;
	cart_pkg::fill_pattern_e           fill_pattern;
	logic                              rom_wr;
	logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr;
	logic [cart_pkg::IOCTL_DATA_W-1:0] rom_data;
	logic [7:0]                        rom_type;
	logic [cart_pkg::ROM_ADDR_W-1:0]   rom_mask;
	logic [cart_pkg::ROM_ADDR_W-1:0]   ram_mask;
	logic                              pal;
	logic [cart_pkg::CODE_FIELD_W-1:0] code_flags;
	logic [cart_pkg::CODE_FIELD_W-1:0] code_address;
	logic [cart_pkg::CODE_FIELD_W-1:0] code_compare;
	logic [cart_pkg::CODE_FIELD_W-1:0] code_replace;
	logic                              code_valid;
	logic                              clearing;
	logic                              fill_we;
	logic [cart_pkg::FILL_ADDR_W-1:0]  fill_addr;
	logic [7:0]                        fill_data;

	logic [31:0] lcg_state = 32'd40;
	int          valid_pulses = 0;

	cart_loader_top cart_loader_top_inst (.*);

	always #4 clk_sys = ~clk_sys;

	// Pulses seen on the cheat record strobe
	always @(negedge clk_sys) begin
		if (code_valid)
			valid_pulses++;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// ========================================================================
	// Compare tasks
	// ========================================================================
	task automatic stop_run();
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_mask(input string name, input logic [cart_pkg::ROM_ADDR_W-1:0] got,
			input logic [cart_pkg::ROM_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_word(input string name, input logic [cart_pkg::IOCTL_DATA_W-1:0] got,
			input logic [cart_pkg::IOCTL_DATA_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_field(input string name, input logic [cart_pkg::CODE_FIELD_W-1:0] got,
			input logic [cart_pkg::CODE_FIELD_W-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			stop_run();
		end
	endtask

	// ========================================================================
	// Host side
	// ========================================================================
	task automatic begin_download(input logic [7:0] index);
		@(negedge clk_sys);
		ioctl_index    = index;
		ioctl_download = 1'b1;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	// Returns one cycle after the word was taken
	task automatic host_word(input logic [cart_pkg::IOCTL_ADDR_W-1:0] addr,
			input logic [cart_pkg::IOCTL_DATA_W-1:0] data);
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	// ========================================================================
	// Tests
	// ========================================================================
	task automatic test_rom_routing();
		logic [31:0]                       r;
		logic [cart_pkg::IOCTL_ADDR_W-1:0] addr;
		logic [cart_pkg::IOCTL_ADDR_W-1:0] stripped;
		begin_download(8'h01);
		repeat (16) begin
			r        = lcg_next();
			addr     = r[24:0];
			stripped = addr - 25'd512;
			r        = lcg_next();
			host_word(addr, r[31:16]);
			check_bit("rom_wr", rom_wr, 1'b1);
			check_mask("rom_addr", rom_addr, stripped[23:0]);
			check_word("rom_data", rom_data, r[31:16]);
		end
		end_download();
		// Index 2 is neither cartridge nor cheat
		begin_download(8'h02);
		repeat (4) begin
			r = lcg_next();
			host_word(r[24:0], r[31:16]);
			check_bit("rom_wr", rom_wr, 1'b0);
		end
		end_download();
	endtask

	task automatic test_auto_header();
		header_mode = cart_pkg::HDR_AUTO;
		begin_download(8'h01);
		host_word(25'd0, 16'h213B);
		end_download();
		check_byte("rom_type", rom_type, 8'h21);
		check_mask("rom_mask", rom_mask, (24'd1024 << 11) - 24'd1);
		check_mask("ram_mask", ram_mask, (24'd1024 << 3) - 24'd1);
	endtask

	task automatic test_hirom_header();
		header_mode = cart_pkg::HDR_HIROM;
		begin_download(8'h01);
		host_word(25'd0, 16'h5A3B);
		host_word(cart_pkg::HIROM_INFO_ADDR, 16'h0A00);
		host_word(cart_pkg::HIROM_INFO_ADDR + 25'd2, 16'h0000);
		end_download();
		check_byte("rom_type", rom_type, 8'h01);
		check_mask("rom_mask", rom_mask, (24'd1024 << 10) - 24'd1);
		check_mask("ram_mask", ram_mask, 24'd0);
		header_mode = cart_pkg::HDR_AUTO;
	endtask

	task automatic test_region();
		region_mode = cart_pkg::REG_AUTO;
		begin_download(8'h01);
		host_word(25'd2, 16'h0100);
		end_download();
		// cart_active drops, then pal follows
		repeat (2) @(negedge clk_sys);
		check_bit("pal", pal, 1'b1);
		region_mode = cart_pkg::REG_NTSC;
		@(negedge clk_sys);
		check_bit("pal", pal, 1'b0);
	endtask

	task automatic test_cheat_record();
		logic [15:0] w [8];
		logic [31:0] r;
		int          t;
		valid_pulses = 0;
		begin_download(8'hFF);
		for (int i = 0; i < 8; i++) begin
			r    = lcg_next();
			w[i] = r[31:16];
			host_word(25'(2 * i), w[i]);
		end
		end_download();
		t = 0;
		while (valid_pulses == 0) begin
			@(negedge clk_sys);
			t++;
			if (t > 20) begin
				$display("code_valid never pulsed after the cheat record");
				stop_run();
			end
		end
		repeat (4) @(negedge clk_sys);
		check_byte("code_valid pulses", valid_pulses[7:0], 8'd1);
		check_field("code_flags", code_flags, {w[1], w[0]});
		check_field("code_address", code_address, {w[3], w[2]});
		check_field("code_compare", code_compare, {w[5], w[4]});
		check_field("code_replace", code_replace, {w[7], w[6]});
	endtask

	task automatic test_ram_fill();
		int         t;
		int         writes;
		logic [7:0] exp;
		t = 0;
		while (clearing) begin
			@(negedge clk_sys);
			t++;
			if (t > (1 << 20)) begin
				$display("earlier RAM clear never finished");
				stop_run();
			end
		end
		fill_pattern = cart_pkg::FILL_SNES2;
		begin_download(8'h00);
		end_download();
		t = 0;
		while (!clearing) begin
			@(negedge clk_sys);
			t++;
			if (t > 10) begin
				$display("clearing did not rise after the cartridge start");
				stop_run();
			end
		end
		writes = 0;
		t      = 0;
		while (clearing) begin
			if (fill_we) begin
				// Pattern of the address this write should carry
				exp = (writes[8] ^ writes[2]) ? 8'h66 : 8'h99;
				check_mask("fill_addr", {6'd0, fill_addr}, writes[23:0]);
				check_byte("fill_data", fill_data, exp);
				writes++;
			end
			@(negedge clk_sys);
			t++;
			if (t > (1 << 20)) begin
				$display("RAM clear did not finish in time");
				stop_run();
			end
		end
		check_mask("fill write count", writes[23:0], 24'd1 << cart_pkg::FILL_ADDR_W);
	endtask

	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = cart_pkg::HDR_AUTO;
		region_mode    = cart_pkg::REG_AUTO;
		fill_pattern   = cart_pkg::FILL_SNES2;
		repeat (2) @(negedge clk_sys);
		RESET = 1'b0;
		check_bit("rom_wr", rom_wr, 1'b0);
		check_bit("code_valid", code_valid, 1'b0);
		check_bit("fill_we", fill_we, 1'b0);
		check_bit("clearing", clearing, 1'b0);
		check_bit("pal", pal, 1'b0);
		test_rom_routing();
		test_auto_header();
		test_hirom_header();
		test_region();
		test_cheat_record();
		test_ram_fill();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- design/cart_loader_top.sv
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic [cart_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [cart_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic                                ioctl_wr,
	input  cart_pkg::header_mode_e              header_mode,
	input  cart_pkg::region_mode_e              region_mode,
	input  cart_pkg::fill_pattern_e             fill_pattern,
	output logic                                rom_wr,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     rom_addr,
	output logic [cart_pkg::IOCTL_DATA_W-1:0]   rom_data,
	output logic [7:0]                          rom_type,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     rom_mask,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     ram_mask,
	output logic                                pal,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_flags,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_address,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_compare,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_replace,
	output logic                                code_valid,
	output logic                                clearing,
	output logic                                fill_we,
	output logic [cart_pkg::FILL_ADDR_W-1:0]    fill_addr,
	output logic [7:0]                          fill_data
);

	// Registered host word from the router
	cart_pkg::load_kind_e              kind;
	logic                              word_wr;
	logic [cart_pkg::IOCTL_ADDR_W-1:0] word_addr;
	logic [cart_pkg::IOCTL_DATA_W-1:0] word_data;
	logic                              cart_active;
	logic                              cart_start;

	// ========================================================================
	// Stages
	// ========================================================================
	download_router download_router_inst (
		.clk_sys, .RESET,
		.ioctl_download, .ioctl_index, .ioctl_addr, .ioctl_dout, .ioctl_wr,
		.kind, .word_wr, .word_addr, .word_data,
		.cart_active, .cart_start,
		.rom_wr, .rom_addr, .rom_data
	);

	rom_header_parser rom_header_parser_inst (
		.clk_sys, .RESET,
		.kind, .word_wr, .word_addr, .word_data, .cart_active,
		.header_mode, .region_mode,
		.rom_type, .rom_mask, .ram_mask, .pal
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys, .RESET,
		.kind, .word_wr, .word_addr, .word_data,
		.code_flags, .code_address, .code_compare, .code_replace, .code_valid
	);

	// Work RAM clear on each new cartridge
	ram_fill_sequencer ram_fill_sequencer_inst (
		.clk_sys, .RESET,
		.cart_start, .fill_pattern,
		.clearing, .fill_we, .fill_addr, .fill_data
	);

endmodule

//--- design/ram_fill_sequencer.sv
`timescale 1ns/1ps

module ram_fill_sequencer (
	input  logic                               clk_sys,
	input  logic                               RESET,
	input  logic                               cart_start,
	input  cart_pkg::fill_pattern_e            fill_pattern,
	output logic                               clearing,
	output logic                               fill_we,
	output logic [cart_pkg::FILL_ADDR_W-1:0]   fill_addr,
	output logic [7:0]                         fill_data
);

	// ========================================================================
	// Address walk, one write then one wait per address
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing  <= 1'b0;
			fill_we   <= 1'b0;
			fill_addr <= '0;
		end else if (!clearing) begin
			fill_addr <= '0;
			clearing  <= cart_start;
			fill_we   <= cart_start;
		end else if (fill_we) begin
			fill_we <= 1'b0;
			// Done after the top address is written
			if (&fill_addr)
				clearing <= 1'b0;
		end else begin
			fill_we   <= 1'b1;
			fill_addr <= fill_addr + 1'b1;
		end
	end

	// Power-on patterns
	always_comb begin
		case (fill_pattern)
			cart_pkg::FILL_SNES2: fill_data = (fill_addr[8] ^ fill_addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_SNES1: fill_data = (fill_addr[9] ^ fill_addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:    fill_data = 8'h55;
			default:              fill_data = 8'hFF;
		endcase
	end

	a_we_in_clear: assert property (@(posedge clk_sys) disable iff (RESET)
		fill_we |-> clearing)
		else $error("fill_we outside the clearing window");

endmodule

//--- design/cheat_code_assembler.sv
`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  cart_pkg::load_kind_e                kind,
	input  logic                                word_wr,
	input  logic [cart_pkg::IOCTL_ADDR_W-1:0]   word_addr,
	input  logic [cart_pkg::IOCTL_DATA_W-1:0]   word_data,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_flags,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_address,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_compare,
	output logic [cart_pkg::CODE_FIELD_W-1:0]   code_replace,
	output logic                                code_valid
);

	localparam int LO = cart_pkg::IOCTL_DATA_W;

	logic code_wr;

	assign code_wr = word_wr && (kind == cart_pkg::KIND_CODE);

	// Last word of the record closes it
	always_ff @(posedge clk_sys) begin
		if (RESET)
			code_valid <= 1'b0;
		else
			code_valid <= code_wr && (word_addr[3:0] == 4'd14);
	end

	// ========================================================================
	// Record slots, low half first
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word_addr[3:0])
				4'd0:  code_flags[LO-1:0]                     <= word_data;
				4'd2:  code_flags[cart_pkg::CODE_FIELD_W-1:LO]   <= word_data;
				4'd4:  code_address[LO-1:0]                   <= word_data;
				4'd6:  code_address[cart_pkg::CODE_FIELD_W-1:LO] <= word_data;
				4'd8:  code_compare[LO-1:0]                   <= word_data;
				4'd10: code_compare[cart_pkg::CODE_FIELD_W-1:LO] <= word_data;
				4'd12: code_replace[LO-1:0]                   <= word_data;
				4'd14: code_replace[cart_pkg::CODE_FIELD_W-1:LO] <= word_data;
				default: ;
			endcase
		end
	end

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid)
		else $error("code_valid held for two cycles");

endmodule

//--- design/rom_header_parser.sv
`timescale 1ns/1ps

module rom_header_parser (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  cart_pkg::load_kind_e                kind,
	input  logic                                word_wr,
	input  logic [cart_pkg::IOCTL_ADDR_W-1:0]   word_addr,
	input  logic [cart_pkg::IOCTL_DATA_W-1:0]   word_data,
	input  logic                                cart_active,
	input  cart_pkg::header_mode_e              header_mode,
	input  cart_pkg::region_mode_e              region_mode,
	output logic [7:0]                          rom_type,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     rom_mask,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     ram_mask,
	output logic                                pal
);

	logic                              cart_wr;
	logic                              fixed_mode;
	logic [cart_pkg::IOCTL_ADDR_W-1:0] info_addr;
	logic [3:0]                        rom_size;
	logic [3:0]                        ram_size;
	logic                              rom_region;
	logic [4:0]                        rom_shift;
	logic [4:0]                        ram_shift;

	assign cart_wr = word_wr && (kind == cart_pkg::KIND_CART);

	// Size info location for the fixed mappings
	always_comb begin
		fixed_mode = 1'b1;
		case (header_mode)
			cart_pkg::HDR_LOROM:   info_addr = cart_pkg::LOROM_INFO_ADDR;
			cart_pkg::HDR_HIROM:   info_addr = cart_pkg::HIROM_INFO_ADDR;
			cart_pkg::HDR_EXHIROM: info_addr = cart_pkg::EXHIROM_INFO_ADDR;
			default: begin
				fixed_mode = 1'b0;
				info_addr  = '0;
			end
		endcase
	end

	// ========================================================================
	// Header capture
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_type   <= 8'd0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else begin
			if (cart_wr) begin
				if (word_addr == '0) begin
					rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
					ram_size <= 4'd0;
					// Auto mode trusts a nonzero size byte
					if (header_mode == cart_pkg::HDR_AUTO && word_data[7:0] != 8'd0)
						{ram_size, rom_size} <= word_data[7:0];

					case (header_mode)
						cart_pkg::HDR_NONE,
						cart_pkg::HDR_LOROM:   rom_type <= 8'd0;
						cart_pkg::HDR_HIROM:   rom_type <= 8'd1;
						cart_pkg::HDR_EXHIROM: rom_type <= 8'd2;
						default:               rom_type <= word_data[15:8];
					endcase
				end

				if (word_addr == cart_pkg::REGION_WORD_ADDR)
					rom_region <= word_data[8];

				if (fixed_mode) begin
					if (word_addr == info_addr)
						rom_size <= word_data[11:8];
					if (word_addr == info_addr + cart_pkg::INFO_RAM_OFFSET)
						ram_size <= word_data[3:0];
				end
			end

			// Region is only applied between downloads
			if (!cart_active) begin
				case (region_mode)
					cart_pkg::REG_AUTO: pal <= rom_region;
					cart_pkg::REG_NTSC: pal <= 1'b0;
					default:            pal <= 1'b1;
				endcase
			end
		end
	end

	// 1024 << size, minus one
	assign rom_shift = {1'b0, rom_size} + 5'd10;
	assign ram_shift = {1'b0, ram_size} + 5'd10;

	assign rom_mask = ~({cart_pkg::ROM_ADDR_W{1'b1}} << rom_shift);
	assign ram_mask = (ram_size != 4'd0) ? ~({cart_pkg::ROM_ADDR_W{1'b1}} << ram_shift) : '0;

endmodule

//--- design/download_router.sv
`timescale 1ns/1ps

module download_router (
	input  logic                                clk_sys,
	input  logic                                RESET,
	input  logic                                ioctl_download,
	input  logic [7:0]                          ioctl_index,
	input  logic [cart_pkg::IOCTL_ADDR_W-1:0]   ioctl_addr,
	input  logic [cart_pkg::IOCTL_DATA_W-1:0]   ioctl_dout,
	input  logic                                ioctl_wr,
	output cart_pkg::load_kind_e                kind,
	output logic                                word_wr,
	output logic [cart_pkg::IOCTL_ADDR_W-1:0]   word_addr,
	output logic [cart_pkg::IOCTL_DATA_W-1:0]   word_data,
	output logic                                cart_active,
	output logic                                cart_start,
	output logic                                rom_wr,
	output logic [cart_pkg::ROM_ADDR_W-1:0]     rom_addr,
	output logic [cart_pkg::IOCTL_DATA_W-1:0]   rom_data
);

	logic                              code_sel;
	logic                              cart_sel;
	logic                              cart_dl;
	logic [cart_pkg::IOCTL_ADDR_W-1:0] stripped_addr;
	cart_pkg::load_kind_e              kind_next;

	// Index decode, index zero also loads a cartridge
	assign code_sel = (ioctl_index == cart_pkg::CODE_INDEX);
	assign cart_sel = (ioctl_index[5:0] == cart_pkg::CART_INDEX) || (ioctl_index == 8'd0);
	assign cart_dl  = ioctl_download && cart_sel;

	assign stripped_addr = ioctl_addr - cart_pkg::CART_HEADER_BYTES;

	always_comb begin
		if (!ioctl_download)
			kind_next = cart_pkg::KIND_NONE;
		else if (code_sel)
			kind_next = cart_pkg::KIND_CODE;
		else if (cart_sel)
			kind_next = cart_pkg::KIND_CART;
		else
			kind_next = cart_pkg::KIND_OTHER;
	end

	// ========================================================================
	// Control registers
	// ========================================================================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			kind        <= cart_pkg::KIND_NONE;
			word_wr     <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
			rom_wr      <= 1'b0;
		end else begin
			kind        <= kind_next;
			word_wr     <= ioctl_wr && ioctl_download;
			cart_active <= cart_dl;
			// Rising edge of the cartridge level
			cart_start  <= cart_dl && !cart_active;
			rom_wr      <= ioctl_wr && cart_dl;
		end
	end

	// Word payload
	always_ff @(posedge clk_sys) begin
		word_addr <= ioctl_addr;
		word_data <= ioctl_dout;
		rom_addr  <= stripped_addr[cart_pkg::ROM_ADDR_W-1:0];
	end

	// ROM port shares the registered data word
	assign rom_data = word_data;

	a_rom_wr_cart: assert property (@(posedge clk_sys) disable iff (RESET)
		rom_wr |-> kind == cart_pkg::KIND_CART)
		else $error("rom_wr outside a cartridge download");

endmodule

//--- design/cart_pkg.sv
package cart_pkg;

	// ========================================================================
	// Widths
	// ========================================================================
	localparam int IOCTL_ADDR_W = 25;
	localparam int IOCTL_DATA_W = 16;
	localparam int ROM_ADDR_W   = 24;
	localparam int FILL_ADDR_W  = 18;
	localparam int CODE_FIELD_W = 32;

	// Host index codes
	localparam logic [7:0] CODE_INDEX = 8'hFF;
	localparam logic [5:0] CART_INDEX = 6'h01;

	// ========================================================================
	// Header layout
	// ========================================================================
	// Copier header in front of the ROM image
	localparam logic [IOCTL_ADDR_W-1:0] CART_HEADER_BYTES = 25'd512;
	localparam logic [3:0]              DEFAULT_ROM_SIZE  = 4'd12;

	// Word holding the region flag in bit 8
	localparam logic [IOCTL_ADDR_W-1:0] REGION_WORD_ADDR = 25'd2;

	// Size byte pair per mapping, as host byte addresses
	localparam logic [IOCTL_ADDR_W-1:0] LOROM_INFO_ADDR   = 25'h007FD6 + CART_HEADER_BYTES;
	localparam logic [IOCTL_ADDR_W-1:0] HIROM_INFO_ADDR   = 25'h00FFD6 + CART_HEADER_BYTES;
	localparam logic [IOCTL_ADDR_W-1:0] EXHIROM_INFO_ADDR = 25'h40FFD6 + CART_HEADER_BYTES;
	// RAM size word sits just above the ROM size word
	localparam logic [IOCTL_ADDR_W-1:0] INFO_RAM_OFFSET   = 25'd2;

	// ========================================================================
	// Enums
	// ========================================================================
	typedef enum logic [1:0] {
		KIND_NONE,
		KIND_CART,
		KIND_CODE,
		KIND_OTHER
	} load_kind_e;

	typedef enum logic [2:0] {
		HDR_AUTO,
		HDR_NONE,
		HDR_LOROM,
		HDR_HIROM,
		HDR_EXHIROM
	} header_mode_e;

	// REG_PAL_ALT behaves as PAL
	typedef enum logic [1:0] {REG_AUTO, REG_NTSC, REG_PAL, REG_PAL_ALT} region_mode_e;

	typedef enum logic [1:0] {FILL_SNES2, FILL_SNES1, FILL_55, FILL_FF} fill_pattern_e;

endpackage
